// File: hdl/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Datapath and register file sizes
`define RV_XLEN        32
`define RV_REG_COUNT   32
`define RV_REG_ADDR_W  5
`define RV_MBE_W       4

// Major opcodes of the supported subset
`define RV_OP_IMM      7'b0010011
`define RV_OP_REG      7'b0110011
`define RV_OP_LUI      7'b0110111
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011

// addi x0, x0, 0
`define RV_NOP         32'h0000_0013

`endif

// File: hdl/rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

  // Fields of one instruction, immediates already formed
  typedef struct packed {
    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]       i_imm;
    logic [`RV_XLEN-1:0]       s_imm;
    logic [`RV_XLEN-1:0]       u_imm;
  } instr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  typedef enum logic [1:0] {
    OP2_REG,
    OP2_IMM_I,
    OP2_IMM_S
  } op2_sel_t;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_UIMM,
    WB_MEM
  } wb_sel_t;

  typedef struct packed {
    alu_op_t  alu_op;
    op2_sel_t op2_sel;
    wb_sel_t  wb_sel;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
  } ctrl_t;

  // Source of an EX operand
  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_EXMEM,
    FWD_MEMWB
  } fwd_sel_t;

endpackage : rv_pkg

// File: hdl/hazard_ctrl.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module hazard_ctrl (
  input  logic                      icache_read,
  input  logic                      icache_resp,
  input  logic                      dcache_read,
  input  logic                      dcache_write,
  input  logic                      dcache_resp,
  input  logic [`RV_REG_ADDR_W-1:0] idex_rs1,
  input  logic [`RV_REG_ADDR_W-1:0] idex_rs2,
  input  logic [`RV_REG_ADDR_W-1:0] exmem_rd,
  input  logic [`RV_REG_ADDR_W-1:0] memwb_rd,
  input  logic                      exmem_wr,
  input  logic                      memwb_wr,
  input  logic [`RV_REG_ADDR_W-1:0] exmem_rs2,
  output logic                      advance,
  output rv_pkg::fwd_sel_t          fwd_a_sel,
  output rv_pkg::fwd_sel_t          fwd_b_sel,
  output logic                      fwd_store
);

  logic icache_stall;
  logic dcache_stall;

  // Nearest valid writer of rs wins, x0 never forwards
  function automatic rv_pkg::fwd_sel_t pick_source(
    input logic [`RV_REG_ADDR_W-1:0] rs,
    input logic [`RV_REG_ADDR_W-1:0] ex_rd,
    input logic                      ex_wr,
    input logic [`RV_REG_ADDR_W-1:0] wb_rd,
    input logic                      wb_wr
  );
    if (ex_wr && ex_rd != '0 && ex_rd == rs) begin
      return rv_pkg::FWD_EXMEM;
    end
    if (wb_wr && wb_rd != '0 && wb_rd == rs) begin
      return rv_pkg::FWD_MEMWB;
    end
    return rv_pkg::FWD_NONE;
  endfunction

  // Any request still waiting for resp freezes the whole pipeline
  assign icache_stall = icache_read & ~icache_resp;
  assign dcache_stall = (dcache_read | dcache_write) & ~dcache_resp;
  assign advance      = ~icache_stall & ~dcache_stall;

  assign fwd_a_sel = pick_source(idex_rs1, exmem_rd, exmem_wr, memwb_rd, memwb_wr);
  assign fwd_b_sel = pick_source(idex_rs2, exmem_rd, exmem_wr, memwb_rd, memwb_wr);

  // Store in MEM picks up the value being written back
  assign fwd_store = dcache_write & memwb_wr & (memwb_rd != '0) & (memwb_rd == exmem_rs2);

endmodule : hazard_ctrl

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module fetch_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                advance,
  input  logic [`RV_XLEN-1:0] icache_rdata,
  output logic [`RV_XLEN-1:0] icache_address,
  output logic                icache_read,
  output rv_pkg::instr_t      ifid_instr,
  output logic                ifid_valid
);

  logic [`RV_XLEN-1:0] pc;
  logic                fetch_en;

  function automatic rv_pkg::instr_t decode_word(input logic [`RV_XLEN-1:0] word);
    rv_pkg::instr_t d;
    d.opcode = word[6:0];
    d.funct3 = word[14:12];
    d.funct7 = word[31:25];
    d.rs1    = word[19:15];
    d.rs2    = word[24:20];
    d.rd     = word[11:7];
    d.i_imm  = {{21{word[31]}}, word[30:20]};
    d.s_imm  = {{21{word[31]}}, word[30:25], word[11:7]};
    d.u_imm  = {word[31:12], 12'h000};
    return d;
  endfunction

  // Fetch requests begin on the first edge out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_en <= 1'b0;
    end else begin
      fetch_en <= 1'b1;
    end
  end

  assign icache_read    = fetch_en;
  assign icache_address = {pc[`RV_XLEN-1:2], 2'b00};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc         <= '0;
      ifid_valid <= 1'b0;
    end else if (advance) begin
      if (fetch_en) begin
        pc <= pc + `RV_XLEN'd4;
      end
      ifid_valid <= fetch_en;
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if (advance) begin
      ifid_instr <= decode_word(icache_rdata);
    end
  end

endmodule : fetch_stage

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module decode_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      advance,
  input  rv_pkg::instr_t            ifid_instr,
  input  logic                      ifid_valid,
  input  logic [`RV_REG_ADDR_W-1:0] wb_rd,
  input  logic [`RV_XLEN-1:0]       wb_data,
  input  logic                      wb_en,
  output rv_pkg::instr_t            idex_instr,
  output rv_pkg::ctrl_t             idex_ctrl,
  output logic [`RV_XLEN-1:0]       idex_rs1_data,
  output logic [`RV_XLEN-1:0]       idex_rs2_data,
  output logic                      idex_valid
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];
  rv_pkg::ctrl_t       ctrl;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;

  // alt selects sub for funct3 000 and sra for funct3 101
  function automatic rv_pkg::alu_op_t alu_from_funct(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  return rv_pkg::ALU_SLL;
      3'b010:  return rv_pkg::ALU_SLT;
      3'b011:  return rv_pkg::ALU_SLTU;
      3'b100:  return rv_pkg::ALU_XOR;
      3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  return rv_pkg::ALU_OR;
      default: return rv_pkg::ALU_AND;
    endcase
  endfunction

  // Register read with x0 tied low and write-through from WB
  function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_ADDR_W-1:0] idx);
    if (idx == '0) begin
      return '0;
    end
    if (wb_en && wb_rd == idx) begin
      return wb_data;
    end
    return regs[idx];
  endfunction

  always_comb begin
    ctrl.alu_op    = rv_pkg::ALU_ADD;
    ctrl.op2_sel   = rv_pkg::OP2_REG;
    ctrl.wb_sel    = rv_pkg::WB_ALU;
    ctrl.reg_write = 1'b0;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;
    case (ifid_instr.opcode)
      `RV_OP_IMM: begin
        ctrl.alu_op    = alu_from_funct(ifid_instr.funct3,
                                        ifid_instr.funct7[5] && ifid_instr.funct3 == 3'b101);
        ctrl.op2_sel   = rv_pkg::OP2_IMM_I;
        ctrl.reg_write = 1'b1;
      end
      `RV_OP_REG: begin
        ctrl.alu_op    = alu_from_funct(ifid_instr.funct3, ifid_instr.funct7[5]);
        ctrl.reg_write = 1'b1;
      end
      `RV_OP_LUI: begin
        ctrl.wb_sel    = rv_pkg::WB_UIMM;
        ctrl.reg_write = 1'b1;
      end
      `RV_OP_LOAD: begin
        ctrl.op2_sel   = rv_pkg::OP2_IMM_I;
        ctrl.wb_sel    = rv_pkg::WB_MEM;
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
      end
      `RV_OP_STORE: begin
        ctrl.op2_sel   = rv_pkg::OP2_IMM_S;
        // Only sb, sh and sw
        ctrl.mem_write = (ifid_instr.funct3 inside {3'b000, 3'b001, 3'b010});
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    rs1_data = read_port(ifid_instr.rs1);
    rs2_data = read_port(ifid_instr.rs2);
  end

  always_ff @(posedge clk) begin
    if (wb_en && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idex_valid <= 1'b0;
    end else if (advance) begin
      idex_valid <= ifid_valid;
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    if (advance) begin
      idex_instr    <= ifid_instr;
      idex_ctrl     <= ctrl;
      idex_rs1_data <= rs1_data;
      idex_rs2_data <= rs2_data;
    end
  end

endmodule : decode_stage

// File: hdl/execute_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module execute_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                advance,
  input  rv_pkg::instr_t      idex_instr,
  input  rv_pkg::ctrl_t       idex_ctrl,
  input  logic [`RV_XLEN-1:0] idex_rs1_data,
  input  logic [`RV_XLEN-1:0] idex_rs2_data,
  input  logic                idex_valid,
  input  rv_pkg::fwd_sel_t    fwd_a_sel,
  input  rv_pkg::fwd_sel_t    fwd_b_sel,
  input  logic [`RV_XLEN-1:0] exmem_fwd_value,
  input  logic [`RV_XLEN-1:0] memwb_fwd_value,
  output rv_pkg::instr_t      exmem_instr,
  output rv_pkg::ctrl_t       exmem_ctrl,
  output logic [`RV_XLEN-1:0] exmem_result,
  output logic [`RV_XLEN-1:0] exmem_store_data,
  output logic                exmem_valid
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] rs2_val;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] result;
  logic [4:0]          shamt;

  function automatic logic [`RV_XLEN-1:0] fwd_pick(
    input rv_pkg::fwd_sel_t    sel,
    input logic [`RV_XLEN-1:0] reg_val,
    input logic [`RV_XLEN-1:0] ex_val,
    input logic [`RV_XLEN-1:0] wb_val
  );
    case (sel)
      rv_pkg::FWD_EXMEM: return ex_val;
      rv_pkg::FWD_MEMWB: return wb_val;
      default:           return reg_val;
    endcase
  endfunction

  assign op_a    = fwd_pick(fwd_a_sel, idex_rs1_data, exmem_fwd_value, memwb_fwd_value);
  assign rs2_val = fwd_pick(fwd_b_sel, idex_rs2_data, exmem_fwd_value, memwb_fwd_value);

  always_comb begin
    case (idex_ctrl.op2_sel)
      rv_pkg::OP2_IMM_I: op_b = idex_instr.i_imm;
      rv_pkg::OP2_IMM_S: op_b = idex_instr.s_imm;
      default:           op_b = rs2_val;
    endcase
  end

  assign shamt = op_b[4:0];

  always_comb begin
    case (idex_ctrl.alu_op)
      rv_pkg::ALU_SUB:  result = op_a - op_b;
      rv_pkg::ALU_SLL:  result = op_a << shamt;
      rv_pkg::ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
      rv_pkg::ALU_XOR:  result = op_a ^ op_b;
      rv_pkg::ALU_SRL:  result = op_a >> shamt;
      rv_pkg::ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::ALU_OR:   result = op_a | op_b;
      rv_pkg::ALU_AND:  result = op_a & op_b;
      default:          result = op_a + op_b;
    endcase
    // lui bypasses the ALU
    if (idex_ctrl.wb_sel == rv_pkg::WB_UIMM) begin
      result = idex_instr.u_imm;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      exmem_valid <= 1'b0;
    end else if (advance) begin
      exmem_valid <= idex_valid;
    end
  end

  // EX/MEM payload, store data leaves already forwarded
  always_ff @(posedge clk) begin
    if (advance) begin
      exmem_instr      <= idex_instr;
      exmem_ctrl       <= idex_ctrl;
      exmem_result     <= result;
      exmem_store_data <= rs2_val;
    end
  end

endmodule : execute_stage

// File: hdl/mem_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module mem_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      advance,
  input  rv_pkg::instr_t            exmem_instr,
  input  rv_pkg::ctrl_t             exmem_ctrl,
  input  logic [`RV_XLEN-1:0]       exmem_result,
  input  logic [`RV_XLEN-1:0]       exmem_store_data,
  input  logic                      exmem_valid,
  input  logic                      fwd_store,
  input  logic [`RV_XLEN-1:0]       dcache_rdata,
  output logic [`RV_XLEN-1:0]       dcache_address,
  output logic                      dcache_read,
  output logic                      dcache_write,
  output logic [`RV_XLEN-1:0]       dcache_wdata,
  output logic [`RV_MBE_W-1:0]      dcache_mbe,
  output logic [`RV_XLEN-1:0]       exmem_fwd_value,
  output logic [`RV_XLEN-1:0]       memwb_fwd_value,
  output logic [`RV_REG_ADDR_W-1:0] wb_rd,
  output logic [`RV_XLEN-1:0]       wb_data,
  output logic                      wb_en
);

  logic [1:0]                byte_off;
  logic [`RV_XLEN-1:0]       store_val;
  logic [`RV_XLEN-1:0]       load_shifted;
  logic [`RV_XLEN-1:0]       load_data;

  logic                      memwb_valid;
  rv_pkg::ctrl_t             memwb_ctrl;
  logic [`RV_REG_ADDR_W-1:0] memwb_rd;
  logic [`RV_XLEN-1:0]       memwb_result;
  logic [`RV_XLEN-1:0]       memwb_load_data;

  assign byte_off       = exmem_result[1:0];
  assign dcache_address = {exmem_result[`RV_XLEN-1:2], 2'b00};
  assign dcache_read    = exmem_valid & exmem_ctrl.mem_read;
  assign dcache_write   = exmem_valid & exmem_ctrl.mem_write;

  assign store_val = fwd_store ? wb_data : exmem_store_data;

  // Store lanes follow the byte offset
  always_comb begin
    dcache_wdata = store_val << {byte_off, 3'b000};
    case (exmem_instr.funct3[1:0])
      2'b00:   dcache_mbe = 4'b0001 << byte_off;
      2'b01:   dcache_mbe = 4'b0011 << byte_off;
      2'b10: begin
        // sw goes out unshifted
        dcache_wdata = store_val;
        dcache_mbe   = 4'b1111;
      end
      default: dcache_mbe = 4'b0000;
    endcase
  end

  always_comb begin
    load_shifted = dcache_rdata >> {byte_off, 3'b000};
    case (exmem_instr.funct3)
      3'b000:  load_data = {{24{load_shifted[7]}}, load_shifted[7:0]};
      3'b001:  load_data = {{16{load_shifted[15]}}, load_shifted[15:0]};
      3'b100:  load_data = {24'b0, load_shifted[7:0]};
      3'b101:  load_data = {16'b0, load_shifted[15:0]};
      default: load_data = dcache_rdata;
    endcase
  end

  // Load data goes straight back to EX with no load-use bubble
  always_comb begin
    case (exmem_ctrl.wb_sel)
      rv_pkg::WB_MEM:  exmem_fwd_value = load_data;
      default:         exmem_fwd_value = exmem_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      memwb_valid <= 1'b0;
    end else if (advance) begin
      memwb_valid <= exmem_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      memwb_ctrl      <= exmem_ctrl;
      memwb_rd        <= exmem_instr.rd;
      memwb_result    <= exmem_result;
      memwb_load_data <= load_data;
    end
  end

  always_comb begin
    case (memwb_ctrl.wb_sel)
      rv_pkg::WB_MEM:  wb_data = memwb_load_data;
      default:         wb_data = memwb_result;
    endcase
  end

  assign wb_rd           = memwb_rd;
  assign wb_en           = memwb_valid & memwb_ctrl.reg_write;
  assign memwb_fwd_value = wb_data;

endmodule : mem_stage

// File: hdl/rv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 icache_resp,
  input  logic [`RV_XLEN-1:0]  icache_rdata,
  output logic [`RV_XLEN-1:0]  icache_address,
  output logic                 icache_read,
  input  logic                 dcache_resp,
  input  logic [`RV_XLEN-1:0]  dcache_rdata,
  output logic [`RV_XLEN-1:0]  dcache_address,
  output logic                 dcache_read,
  output logic                 dcache_write,
  output logic [`RV_XLEN-1:0]  dcache_wdata,
  output logic [`RV_MBE_W-1:0] dcache_mbe
);

  logic                      advance;
  rv_pkg::fwd_sel_t          fwd_a_sel;
  rv_pkg::fwd_sel_t          fwd_b_sel;
  logic                      fwd_store;

  rv_pkg::instr_t            ifid_instr;
  logic                      ifid_valid;

  rv_pkg::instr_t            idex_instr;
  rv_pkg::ctrl_t             idex_ctrl;
  logic [`RV_XLEN-1:0]       idex_rs1_data;
  logic [`RV_XLEN-1:0]       idex_rs2_data;
  logic                      idex_valid;

  rv_pkg::instr_t            exmem_instr;
  rv_pkg::ctrl_t             exmem_ctrl;
  logic [`RV_XLEN-1:0]       exmem_result;
  logic [`RV_XLEN-1:0]       exmem_store_data;
  logic                      exmem_valid;

  logic [`RV_XLEN-1:0]       exmem_fwd_value;
  logic [`RV_XLEN-1:0]       memwb_fwd_value;
  logic [`RV_REG_ADDR_W-1:0] wb_rd;
  logic [`RV_XLEN-1:0]       wb_data;
  logic                      wb_en;

  hazard_ctrl u_hazard (
    .icache_read  (icache_read),
    .icache_resp  (icache_resp),
    .dcache_read  (dcache_read),
    .dcache_write (dcache_write),
    .dcache_resp  (dcache_resp),
    .idex_rs1     (idex_instr.rs1),
    .idex_rs2     (idex_instr.rs2),
    .exmem_rd     (exmem_instr.rd),
    .memwb_rd     (wb_rd),
    .exmem_wr     (exmem_valid & exmem_ctrl.reg_write),
    .memwb_wr     (wb_en),
    .exmem_rs2    (exmem_instr.rs2),
    .advance      (advance),
    .fwd_a_sel    (fwd_a_sel),
    .fwd_b_sel    (fwd_b_sel),
    .fwd_store    (fwd_store)
  );

  fetch_stage u_fetch (.*);

  decode_stage u_decode (.*);

  execute_stage u_execute (.*);

  mem_stage u_mem (.*);

endmodule : rv_core

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 20 ns period
  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

endmodule : tb_clock

// File: test/rv_core_properties.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core_properties (
  input logic                 clk,
  input logic                 rst_n,
  input logic [`RV_XLEN-1:0]  icache_address,
  input logic                 icache_read,
  input logic                 icache_resp,
  input logic [`RV_XLEN-1:0]  dcache_address,
  input logic                 dcache_read,
  input logic                 dcache_write,
  input logic                 dcache_resp,
  input logic [`RV_MBE_W-1:0] dcache_mbe
);

  // Waiting requests keep their address
  a_iaddr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (icache_read && !icache_resp) |=> (icache_read && $stable(icache_address)))
    else $error("icache address changed while the request waited for resp");

  a_daddr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ((dcache_read || dcache_write) && !dcache_resp) |=> $stable(dcache_address))
    else $error("dcache address changed while the request waited for resp");

  a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(dcache_read && dcache_write))
    else $error("dcache read and write both active");

  a_mask_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    dcache_write |-> (dcache_mbe != '0))
    else $error("dcache write with an empty byte mask");

endmodule : rv_core_properties

bind rv_core rv_core_properties u_props (.*);

// File: test/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_rv_core;

  localparam logic [31:0] load_addr = 32'h0000_0120;

  logic                 clk;
  logic                 rst_n;
  logic                 icache_resp;
  logic [`RV_XLEN-1:0]  icache_rdata;
  logic [`RV_XLEN-1:0]  icache_address;
  logic                 icache_read;
  logic                 dcache_resp;
  logic [`RV_XLEN-1:0]  dcache_rdata;
  logic [`RV_XLEN-1:0]  dcache_address;
  logic                 dcache_read;
  logic                 dcache_write;
  logic [`RV_XLEN-1:0]  dcache_wdata;
  logic [`RV_MBE_W-1:0] dcache_mbe;

  // Program table with the store each entry should produce
  logic [31:0] prog_word [$];
  logic        exp_flag [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [3:0]  exp_mask [$];

  // Writes seen on the data port in order
  logic [31:0] obs_addr [$];
  logic [31:0] obs_data [$];
  logic [3:0]  obs_mask [$];

  logic [31:0] dmem [128];
  logic [31:0] lfsr;
  logic [1:0]  i_delay;
  logic [1:0]  d_delay;
  logic        model_adv;
  int          reset_edges;
  int          mismatches;
  int          other_errors;
  int          wait_cycles;
  int          reads_seen;
  int          load_count;
  logic [31:0] got_addr;
  logic [31:0] got_data;
  logic [3:0]  got_mask;

  tb_clock u_clock (.clk(clk));

  rv_core uut (.*);

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic logic [31:0] lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, `RV_OP_LUI};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] mask);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if ((addr >> 2) < prog_word.size()) begin
      return prog_word[addr >> 2];
    end
    return `RV_NOP;
  endfunction

  // Galois LFSR step
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // One LFSR step per delay bit
  task automatic draw_delay(output logic [1:0] d);
    d = '0;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsr_next(lfsr);
      d = {d[0], lfsr[0]};
    end
  endtask

  task automatic put_op(input logic [31:0] word);
    prog_word.push_back(word);
    exp_flag.push_back(1'b0);
    exp_addr.push_back('0);
    exp_data.push_back('0);
    exp_mask.push_back('0);
  endtask

  task automatic put_store(input logic [31:0] word, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] mask);
    prog_word.push_back(word);
    exp_flag.push_back(1'b1);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_mask.push_back(mask);
  endtask

  task automatic report_counts();
    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
  endtask

  task automatic build_program();
    put_op(i_type(12'h123, 0, 3'b000, 1, `RV_OP_IMM));
    put_op(i_type(12'hFFB, 0, 3'b000, 2, `RV_OP_IMM));
    // Each R-type result is stored right away
    put_op(r_type(7'h00, 2, 1, 3'b000, 3));
    put_store(s_type(12'd0, 3, 0, 3'b010), 32'd0, 32'h0000_011E, 4'hF);
    put_op(r_type(7'h20, 2, 1, 3'b000, 3));
    put_store(s_type(12'd4, 3, 0, 3'b010), 32'd4, 32'h0000_0128, 4'hF);
    put_op(r_type(7'h00, 2, 1, 3'b001, 3));
    put_store(s_type(12'd8, 3, 0, 3'b010), 32'd8, 32'h1800_0000, 4'hF);
    put_op(r_type(7'h00, 1, 2, 3'b010, 3));
    put_store(s_type(12'd12, 3, 0, 3'b010), 32'd12, 32'h0000_0001, 4'hF);
    put_op(r_type(7'h00, 1, 2, 3'b011, 3));
    put_store(s_type(12'd16, 3, 0, 3'b010), 32'd16, 32'h0000_0000, 4'hF);
    put_op(r_type(7'h00, 2, 1, 3'b100, 3));
    put_store(s_type(12'd20, 3, 0, 3'b010), 32'd20, 32'hFFFF_FED8, 4'hF);
    put_op(r_type(7'h00, 1, 2, 3'b101, 3));
    put_store(s_type(12'd24, 3, 0, 3'b010), 32'd24, 32'h1FFF_FFFF, 4'hF);
    put_op(r_type(7'h20, 1, 2, 3'b101, 3));
    put_store(s_type(12'd28, 3, 0, 3'b010), 32'd28, 32'hFFFF_FFFF, 4'hF);
    put_op(r_type(7'h00, 2, 1, 3'b110, 3));
    put_store(s_type(12'd32, 3, 0, 3'b010), 32'd32, 32'hFFFF_FFFB, 4'hF);
    put_op(r_type(7'h00, 2, 1, 3'b111, 3));
    put_store(s_type(12'd36, 3, 0, 3'b010), 32'd36, 32'h0000_0123, 4'hF);
    // I-type and lui
    put_op(i_type(12'hFFC, 2, 3'b010, 3, `RV_OP_IMM));
    put_store(s_type(12'd40, 3, 0, 3'b010), 32'd40, 32'h0000_0001, 4'hF);
    put_op(i_type(12'hFFF, 1, 3'b011, 3, `RV_OP_IMM));
    put_store(s_type(12'd44, 3, 0, 3'b010), 32'd44, 32'h0000_0001, 4'hF);
    put_op(i_type(12'h0F0, 1, 3'b100, 3, `RV_OP_IMM));
    put_store(s_type(12'd48, 3, 0, 3'b010), 32'd48, 32'h0000_01D3, 4'hF);
    put_op(i_type(12'h044, 1, 3'b110, 3, `RV_OP_IMM));
    put_store(s_type(12'd52, 3, 0, 3'b010), 32'd52, 32'h0000_0167, 4'hF);
    put_op(i_type(12'h7F0, 2, 3'b111, 3, `RV_OP_IMM));
    put_store(s_type(12'd56, 3, 0, 3'b010), 32'd56, 32'h0000_07F0, 4'hF);
    put_op(i_type(12'h008, 1, 3'b001, 3, `RV_OP_IMM));
    put_store(s_type(12'd60, 3, 0, 3'b010), 32'd60, 32'h0001_2300, 4'hF);
    put_op(i_type(12'h01C, 2, 3'b101, 3, `RV_OP_IMM));
    put_store(s_type(12'd64, 3, 0, 3'b010), 32'd64, 32'h0000_000F, 4'hF);
    put_op(i_type(12'h401, 2, 3'b101, 3, `RV_OP_IMM));
    put_store(s_type(12'd68, 3, 0, 3'b010), 32'd68, 32'hFFFF_FFFD, 4'hF);
    put_op(lui(20'hABCDE, 3));
    put_store(s_type(12'd72, 3, 0, 3'b010), 32'd72, 32'hABCD_E000, 4'hF);
    // Forwarding at distances 2 and 3
    put_op(i_type(12'h055, 0, 3'b000, 4, `RV_OP_IMM));
    put_op(i_type(12'h066, 0, 3'b000, 5, `RV_OP_IMM));
    put_op(i_type(12'h077, 0, 3'b000, 6, `RV_OP_IMM));
    put_op(r_type(7'h00, 5, 4, 3'b000, 7));
    put_store(s_type(12'd76, 7, 0, 3'b010), 32'd76, 32'h0000_00BB, 4'hF);
    put_store(s_type(12'd80, 6, 0, 3'b010), 32'd80, 32'h0000_0077, 4'hF);
    // x0 stays zero
    put_op(i_type(12'h7FF, 0, 3'b000, 0, `RV_OP_IMM));
    put_store(s_type(12'd84, 0, 0, 3'b010), 32'd84, 32'h0000_0000, 4'hF);
    put_op(r_type(7'h00, 1, 0, 3'b000, 8));
    put_store(s_type(12'd88, 8, 0, 3'b010), 32'd88, 32'h0000_0123, 4'hF);
    // Byte and halfword stores at every offset
    put_op(i_type(12'h100, 0, 3'b000, 9, `RV_OP_IMM));
    put_op(lui(20'h12345, 10));
    put_op(i_type(12'h678, 10, 3'b000, 10, `RV_OP_IMM));
    put_store(s_type(12'd0, 10, 9, 3'b000), 32'h100, 32'h1234_5678, 4'b0001);
    put_store(s_type(12'd1, 10, 9, 3'b000), 32'h100, 32'h3456_7800, 4'b0010);
    put_store(s_type(12'd2, 10, 9, 3'b000), 32'h100, 32'h5678_0000, 4'b0100);
    put_store(s_type(12'd3, 10, 9, 3'b000), 32'h100, 32'h7800_0000, 4'b1000);
    put_store(s_type(12'd0, 10, 9, 3'b001), 32'h100, 32'h1234_5678, 4'b0011);
    put_store(s_type(12'd2, 10, 9, 3'b001), 32'h100, 32'h5678_0000, 4'b1100);
    // Each load of the word at 0x120 is stored at once
    put_op(i_type(12'h020, 9, 3'b000, 11, `RV_OP_LOAD));
    put_store(s_type(12'd92, 11, 0, 3'b010), 32'd92, 32'hFFFF_FFA1, 4'hF);
    put_op(i_type(12'h021, 9, 3'b100, 11, `RV_OP_LOAD));
    put_store(s_type(12'd96, 11, 0, 3'b010), 32'd96, 32'h0000_00F0, 4'hF);
    put_op(i_type(12'h022, 9, 3'b001, 11, `RV_OP_LOAD));
    put_store(s_type(12'd100, 11, 0, 3'b010), 32'd100, 32'hFFFF_8765, 4'hF);
    put_op(i_type(12'h020, 9, 3'b101, 11, `RV_OP_LOAD));
    put_store(s_type(12'd104, 11, 0, 3'b010), 32'd104, 32'h0000_F0A1, 4'hF);
    put_op(i_type(12'h020, 9, 3'b010, 11, `RV_OP_LOAD));
    put_store(s_type(12'd108, 11, 0, 3'b010), 32'd108, 32'h8765_F0A1, 4'hF);
  endtask

  // Cache models hold resp until the pipeline advances
  always @(posedge clk) begin
    model_adv = (!icache_read || icache_resp) &&
                (!(dcache_read || dcache_write) || dcache_resp);
    if (!rst_n) begin
      icache_resp <= 1'b0;
      dcache_resp <= 1'b0;
      draw_delay(i_delay);
      draw_delay(d_delay);
    end else begin
      if (icache_read) begin
        if (icache_resp) begin
          if (model_adv) begin
            icache_resp <= 1'b0;
            draw_delay(i_delay);
          end
        end else if (i_delay == 2'd0) begin
          icache_resp  <= 1'b1;
          icache_rdata <= fetch_word(icache_address);
        end else begin
          i_delay = i_delay - 2'd1;
        end
      end
      if (dcache_read || dcache_write) begin
        if (dcache_resp) begin
          if (model_adv) begin
            dcache_resp <= 1'b0;
            draw_delay(d_delay);
            if (dcache_write) begin
              dmem[dcache_address[8:2]] <= merge_bytes(dmem[dcache_address[8:2]],
                                                       dcache_wdata, dcache_mbe);
            end
          end
        end else if (d_delay == 2'd0) begin
          dcache_resp  <= 1'b1;
          dcache_rdata <= dmem[dcache_address[8:2]];
        end else begin
          d_delay = d_delay - 2'd1;
        end
      end
    end
  end

  // Accepted writes and reads, and the quiet-reset check
  always @(posedge clk) begin
    if (!rst_n) begin
      if (reset_edges > 0) begin
        assert (!icache_read && !dcache_read && !dcache_write) else begin
          $display("A cache request was active during reset at %0t", $time);
          other_errors++;
        end
      end
      reset_edges++;
    end else if (dcache_write && dcache_resp && (!icache_read || icache_resp)) begin
      obs_addr.push_back(dcache_address);
      obs_data.push_back(dcache_wdata);
      obs_mask.push_back(dcache_mbe);
    end else if (dcache_read && dcache_resp && (!icache_read || icache_resp)) begin
      reads_seen++;
      assert (dcache_address == load_addr) else begin
        $display("MISMATCH time=%0t signal=dcache_address expected=%h got=%h",
                 $time, load_addr, dcache_address);
        mismatches++;
      end
    end
  end

  initial begin
    lfsr         = 32'h3028_cb1b;
    rst_n        = 1'b0;
    icache_resp  = 1'b0;
    icache_rdata = '0;
    dcache_resp  = 1'b0;
    dcache_rdata = '0;
    i_delay      = '0;
    d_delay      = '0;
    reset_edges  = 0;
    mismatches   = 0;
    other_errors = 0;
    reads_seen   = 0;
    load_count   = 0;
    for (int i = 0; i < 128; i++) begin
      dmem[i] = 32'h5A00_0000 | (i * 32'h0001_0203);
    end
    dmem[load_addr[8:2]] = 32'h8765_F0A1;
    build_program();

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    for (int k = 0; k < prog_word.size(); k++) begin
      if (exp_flag[k]) begin
        wait_cycles = 0;
        while (obs_addr.size() == 0 && wait_cycles < 200) begin
          @(posedge clk);
          wait_cycles++;
        end
        if (obs_addr.size() == 0) begin
          $display("Timeout: no store seen for table entry %0d", k);
          other_errors++;
          break;
        end else begin
          got_addr = obs_addr.pop_front();
          got_data = obs_data.pop_front();
          got_mask = obs_mask.pop_front();
          assert (got_addr == exp_addr[k]) else begin
            $display("MISMATCH time=%0t signal=dcache_address expected=%h got=%h",
                     $time, exp_addr[k], got_addr);
            mismatches++;
          end
          assert (got_data == exp_data[k]) else begin
            $display("MISMATCH time=%0t signal=dcache_wdata expected=%h got=%h",
                     $time, exp_data[k], got_data);
            mismatches++;
          end
          assert (got_mask == exp_mask[k]) else begin
            $display("MISMATCH time=%0t signal=dcache_mbe expected=%h got=%h",
                     $time, exp_mask[k], got_mask);
            mismatches++;
          end
        end
      end
    end

    // Trailing nops must not write
    wait_cycles = 0;
    while (obs_addr.size() == 0 && wait_cycles < 60) begin
      @(posedge clk);
      wait_cycles++;
    end
    assert (obs_addr.size() == 0) else begin
      $display("Unexpected store after the end of the program");
      other_errors++;
    end

    // One data read per load in the table
    foreach (prog_word[j]) begin
      if (prog_word[j][6:0] == `RV_OP_LOAD) begin
        load_count++;
      end
    end
    assert (reads_seen == load_count) else begin
      $display("Wrong number of data reads: %0d seen for %0d loads", reads_seen, load_count);
      other_errors++;
    end

    report_counts();
    if (mismatches == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_rv_core

// File: rv_pipe.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/hazard_ctrl.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/rv_core.sv
test/tb_clock.sv
test/rv_core_properties.sv
test/tb_rv_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core -f rv_pipe.f

sim_out=$(./obj_dir/Vtb_rv_core)
echo "$sim_out"

if echo "$sim_out" | grep -q "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi
